// ==== de0_glue_pkg.sv ====
/*
 * board widths, default timing and the reset-kind enum for the board glue logic
 * referenced with scoped names (de0_glue_pkg::NAME) from every block and the testbench
 */
`default_nettype none

package de0_glue_pkg;

  // ============================================================
  // board widths
  // ============================================================
  localparam int KEY_COUNT       = 2;   // push keys, active low
  localparam int SW_WIDTH        = 4;   // slide switches
  localparam int LED_WIDTH       = 8;   // board leds
  localparam int LED_PIO_WIDTH   = 7;   // processor led register, drives led[7:1]
  localparam int STM_EVENT_WIDTH = 28;  // trace-event word to the processor

  // reset-request channels, one per kind
  // order matches the request bits and the reset outputs
  typedef enum logic [1:0] {
    RESET_COLD  = 2'd0,
    RESET_WARM  = 2'd1,
    RESET_DEBUG = 2'd2
  } reset_kind_e;

  // bus width follows the last enum value
  localparam int RESET_REQ_COUNT = int'(RESET_DEBUG) + 1;

  // ============================================================
  // default timing at 50 MHz
  // ============================================================
  localparam int DEBOUNCE_CYCLES_DEF = 50_000;      // 1 ms settle time
  localparam int HEARTBEAT_HALF_DEF  = 25_000_000;  // 0.5 s per led half period

  // reset pulse lengths in clock cycles
  localparam int COLD_PULSE_DEF  = 6;
  localparam int WARM_PULSE_DEF  = 2;
  localparam int DEBUG_PULSE_DEF = 32;

  // two-flop synchronizer on all asynchronous inputs
  localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== key_debounce.sv ====
/*
 * synchronizes and debounces active-low push keys; one settle counter per key
 * clean level changes only once the raw level has held for DEBOUNCE_CYCLES
 */
`default_nettype none

module key_debounce #(
  parameter int WIDTH           = de0_glue_pkg::KEY_COUNT,
  parameter int DEBOUNCE_CYCLES = de0_glue_pkg::DEBOUNCE_CYCLES_DEF
) (
  input  wire logic             fpga_clk_50,
  input  wire logic             hps_fpga_reset_n,
  input  wire logic [WIDTH-1:0] key_raw,     // straight from the pins
  output logic      [WIDTH-1:0] key_clean    // released = 1
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

  typedef enum logic {
    ST_STABLE,    // synced level equals output
    ST_SETTLING   // level differs, counting
  } debounce_state_e;

  // ============================================================
  // input synchronizer
  // ============================================================
  logic [WIDTH-1:0] sync_q [de0_glue_pkg::SYNC_STAGES];
  logic [WIDTH-1:0] key_sync;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      for (int i = 0; i < de0_glue_pkg::SYNC_STAGES; i++)
      begin
        sync_q[i] <= '1;                   // keys read released
      end
    end
    else
    begin
      sync_q[0] <= key_raw;
      for (int i = 1; i < de0_glue_pkg::SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign key_sync = sync_q[de0_glue_pkg::SYNC_STAGES-1];

  // ============================================================
  // per-key settle FSM
  // ============================================================
  for (genvar k = 0; k < WIDTH; k++)
  begin : g_key
    debounce_state_e  state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             clean_q;

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        state_q <= ST_STABLE;
        cnt_q   <= '0;
        clean_q <= 1'b1;
      end
      else
      begin
        case (state_q)
          ST_STABLE:
          begin
            if (key_sync[k] != clean_q)
            begin
              state_q <= ST_SETTLING;
              cnt_q   <= CNT_W'(1);        // first differing cycle counts
            end
          end
          ST_SETTLING:
          begin
            if (key_sync[k] == clean_q)
            begin
              state_q <= ST_STABLE;        // glitch, drop it
              cnt_q   <= '0;
            end
            else if (cnt_q == CNT_LAST)
            begin
              state_q <= ST_STABLE;
              cnt_q   <= '0;
              clean_q <= key_sync[k];      // held long enough
            end
            else
            begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          default:
          begin
            state_q <= ST_STABLE;
          end
        endcase
      end
    end

    assign key_clean[k] = clean_q;
  end

endmodule

`default_nettype wire

// ==== reset_req_pulse.sv ====
/*
 * turns one reset-request bit into an active-low pulse of PULSE_CYCLES cycles
 * rising edges that arrive while a pulse is running are ignored
 */
`default_nettype none

module reset_req_pulse #(
  parameter int PULSE_CYCLES = de0_glue_pkg::COLD_PULSE_DEF
) (
  input  wire logic fpga_clk_50,
  input  wire logic hps_fpga_reset_n,
  input  wire logic req,           // asynchronous request level
  output logic      reset_req_n    // low for PULSE_CYCLES after an edge
);

  localparam int SYNC_N = de0_glue_pkg::SYNC_STAGES;
  localparam int CNT_W  = $clog2(PULSE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_START = CNT_W'(PULSE_CYCLES - 1);

  typedef enum logic {
    ST_IDLE,   // waiting for a rising edge
    ST_BUSY    // pulse running
  } pulse_state_e;

  // ============================================================
  // sync and edge detect
  // ============================================================
  logic [SYNC_N-1:0] req_sync_q;
  logic              req_prev_q;
  logic              req_rise;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_sync_q <= '0;
      req_prev_q <= 1'b0;
    end
    else
    begin
      req_sync_q <= {req_sync_q[SYNC_N-2:0], req};
      req_prev_q <= req_sync_q[SYNC_N-1];
    end
  end

  assign req_rise = req_sync_q[SYNC_N-1] & ~req_prev_q;   // one cycle wide

  // ============================================================
  // pulse FSM with down-counter
  // ============================================================
  pulse_state_e     state_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (req_rise)
          begin
            state_q <= ST_BUSY;
            cnt_q   <= CNT_START;     // busy cycles still to go after this one
          end
        end
        ST_BUSY:
        begin
          if (cnt_q == '0)
          begin
            state_q <= ST_IDLE;       // edges seen until here are lost
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // straight decode of the state flop, no glitch
  assign reset_req_n = (state_q != ST_BUSY);

endmodule

`default_nettype wire

// ==== heartbeat_led.sv ====
/*
 * heartbeat blinker, toggles led_level every HEARTBEAT_HALF clock cycles
 */
`default_nettype none

module heartbeat_led #(
  parameter int HEARTBEAT_HALF = de0_glue_pkg::HEARTBEAT_HALF_DEF
) (
  input  wire logic fpga_clk_50,
  input  wire logic hps_fpga_reset_n,
  output logic      led_level        // 0 after reset
);

  localparam int CNT_W = $clog2(HEARTBEAT_HALF + 1);
  localparam logic [CNT_W-1:0] CNT_WRAP = CNT_W'(HEARTBEAT_HALF - 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt_q     <= '0;
      led_level <= 1'b0;
    end
    else if (cnt_q == CNT_WRAP)
    begin
      cnt_q     <= '0;             // wrap, HEARTBEAT_HALF cycles per level
      led_level <= ~led_level;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== de0_glue_top.sv ====
/*
 * board glue top: key debounce, three reset-request pulsers, heartbeat led,
 * led pass-through and the trace-event word sent to the processor
 */
`default_nettype none

module de0_glue_top #(
  parameter int DEBOUNCE_CYCLES = de0_glue_pkg::DEBOUNCE_CYCLES_DEF,
  parameter int HEARTBEAT_HALF  = de0_glue_pkg::HEARTBEAT_HALF_DEF,
  parameter int COLD_PULSE      = de0_glue_pkg::COLD_PULSE_DEF,
  parameter int WARM_PULSE      = de0_glue_pkg::WARM_PULSE_DEF,
  parameter int DEBUG_PULSE     = de0_glue_pkg::DEBUG_PULSE_DEF
) (
  input  wire logic                                     fpga_clk_50,
  input  wire logic                                     hps_fpga_reset_n,
  input  wire logic [de0_glue_pkg::KEY_COUNT-1:0]       key,           // active low
  input  wire logic [de0_glue_pkg::SW_WIDTH-1:0]        sw,
  input  wire logic [de0_glue_pkg::LED_PIO_WIDTH-1:0]   led_pio,       // processor led reg
  input  wire logic [de0_glue_pkg::RESET_REQ_COUNT-1:0] hps_reset_req,
  output logic      [de0_glue_pkg::LED_WIDTH-1:0]       led,
  output logic      [de0_glue_pkg::KEY_COUNT-1:0]       debounced_buttons,
  output logic      [de0_glue_pkg::RESET_REQ_COUNT-1:0] f2h_reset_req_n,
  output logic      [de0_glue_pkg::STM_EVENT_WIDTH-1:0] stm_hw_events
);

  // zero fill above the used event bits
  localparam int EVENT_PAD = de0_glue_pkg::STM_EVENT_WIDTH - de0_glue_pkg::SW_WIDTH
                           - de0_glue_pkg::LED_PIO_WIDTH - de0_glue_pkg::KEY_COUNT;

  // ============================================================
  // keys
  // ============================================================
  key_debounce #(
    .WIDTH           (de0_glue_pkg::KEY_COUNT),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (debounced_buttons)    // to button register
  );

  // ============================================================
  // reset requests, one pulser per kind
  // ============================================================
  reset_req_pulse #(.PULSE_CYCLES(COLD_PULSE)) cold_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[de0_glue_pkg::RESET_COLD]),
    .reset_req_n      (f2h_reset_req_n[de0_glue_pkg::RESET_COLD])
  );

  reset_req_pulse #(.PULSE_CYCLES(WARM_PULSE)) warm_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[de0_glue_pkg::RESET_WARM]),
    .reset_req_n      (f2h_reset_req_n[de0_glue_pkg::RESET_WARM])
  );

  reset_req_pulse #(.PULSE_CYCLES(DEBUG_PULSE)) debug_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[de0_glue_pkg::RESET_DEBUG]),
    .reset_req_n      (f2h_reset_req_n[de0_glue_pkg::RESET_DEBUG])
  );

  // ============================================================
  // leds and event word
  // ============================================================
  heartbeat_led #(.HEARTBEAT_HALF(HEARTBEAT_HALF)) heartbeat_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_level        (led[0])               // blink shows clock and reset alive
  );

  assign led[de0_glue_pkg::LED_WIDTH-1:1] = led_pio;   // processor owns the rest

  // msb to lsb: pad, switches, led register, keys
  assign stm_hw_events = {{EVENT_PAD{1'b0}}, sw, led_pio, debounced_buttons};

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
/*
 * testbench clock and reset source: 50 MHz clock, reset held low for RESET_CYCLES
 */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic fpga_clk_50,
  output logic hps_fpga_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #(PERIOD_NS / 2) fpga_clk_50 = ~fpga_clk_50;
  end

  initial
  begin
    hps_fpga_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge fpga_clk_50);
    #1;
    hps_fpga_reset_n = 1'b1;                 // release off the edge
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
/*
 * testbench checker: watches the glue top outputs on the falling edge, derives
 * expected values, counts errors and prints the closing count line on report
 */
`default_nettype none

module tb_checker #(
  parameter int DEBOUNCE_CYCLES = 16,
  parameter int HEARTBEAT_HALF  = 40
) (
  input  wire logic                                     fpga_clk_50,
  input  wire logic                                     hps_fpga_reset_n,
  input  wire logic [de0_glue_pkg::KEY_COUNT-1:0]       key,          // raw keys as driven
  input  wire logic [de0_glue_pkg::SW_WIDTH-1:0]        sw,
  input  wire logic [de0_glue_pkg::LED_PIO_WIDTH-1:0]   led_pio,
  input  wire logic [de0_glue_pkg::LED_WIDTH-1:0]       led,
  input  wire logic [de0_glue_pkg::KEY_COUNT-1:0]       debounced_buttons,
  input  wire logic [de0_glue_pkg::RESET_REQ_COUNT-1:0] f2h_reset_req_n,
  input  wire logic [de0_glue_pkg::STM_EVENT_WIDTH-1:0] stm_hw_events,
  input  wire logic [8*16-1:0]                          test_name,
  input  wire logic                                     chk_buttons,  // one-cycle strobes
  input  wire logic                                     chk_pulse,
  input  wire logic [31:0]                              chk_arg1,
  input  wire logic [31:0]                              chk_arg2,
  input  wire logic                                     report,
  output int                                            error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int EVW = de0_glue_pkg::STM_EVENT_WIDTH;
  localparam int RRC = de0_glue_pkg::RESET_REQ_COUNT;
  localparam int KC  = de0_glue_pkg::KEY_COUNT;

  int   value_errors  = 0;
  int   other_errors  = 0;
  logic reset_checked = 1'b0;
  logic hb_level      = 1'b0;    // last seen led[0]
  logic hb_toggled    = 1'b0;
  int   hb_cycles     = 0;
  int   hb_timed      = 0;       // toggles with a checked spacing
  int   low_cycles [RRC] = '{default: 0};   // running low time per kind
  int   last_len   [RRC] = '{default: 0};
  int   pulse_seen [RRC] = '{default: 0};   // pulses since last check
  logic [KC-1:0] key_prev = '1;             // raw level at the last edge
  logic [KC-1:0] btn_prev = '1;
  int   key_age    [KC]  = '{default: 0};   // cycles since the raw key moved

  assign error_count = value_errors + other_errors;

  // ============================================================
  // helpers
  // ============================================================
  function automatic string name_str(input logic [8*16-1:0] v);
    string s;
    byte   c;
    s = "";
    for (int i = 15; i >= 0; i--)
    begin
      c = v[8*i +: 8];
      if (c != 0)
        s = $sformatf("%s%c", s, c);   // skip leading pad
    end
    return s;
  endfunction

  function automatic string kind_name(input int k);
    case (de0_glue_pkg::reset_kind_e'(k))
      de0_glue_pkg::RESET_COLD: return "cold";
      de0_glue_pkg::RESET_WARM: return "warm";
      default:                  return "debug";
    endcase
  endfunction

  // pad, switches, led register, keys from msb down
  function automatic logic [EVW-1:0] pack_events(
    input logic [de0_glue_pkg::SW_WIDTH-1:0]      s,
    input logic [de0_glue_pkg::LED_PIO_WIDTH-1:0] l,
    input logic [de0_glue_pkg::KEY_COUNT-1:0]     b
  );
    logic [EVW-1:0] w;
    w = EVW'(b);
    w = w | (EVW'(l) << de0_glue_pkg::KEY_COUNT);
    w = w | (EVW'(s) << (de0_glue_pkg::KEY_COUNT + de0_glue_pkg::LED_PIO_WIDTH));
    return w;
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    value_errors++;
    $display("Error %s %s: expected %0h, actual %0h", name_str(test_name), what, exp, act);
  endtask

  // ============================================================
  // checks
  // ============================================================
  task automatic check_after_reset();
    reset_checked = 1'b1;
    if (led[0] !== 1'b0)
      value_error("heartbeat after reset", 32'd0, 32'(led[0]));
    if (debounced_buttons !== '1)
      value_error("buttons after reset", 32'(3), 32'(debounced_buttons));
    if (f2h_reset_req_n !== '1)
      value_error("reset outputs after reset", 32'(7), 32'(f2h_reset_req_n));
  endtask

  task automatic check_pass_through();
    logic [EVW-1:0] exp_events;
    exp_events = pack_events(sw, led_pio, debounced_buttons);
    if (led[de0_glue_pkg::LED_WIDTH-1:1] !== led_pio)
      value_error("led pass-through", 32'(led_pio), 32'(led[de0_glue_pkg::LED_WIDTH-1:1]));
    if (stm_hw_events !== exp_events)
      value_error("event word", 32'(exp_events), 32'(stm_hw_events));
  endtask

  // clean level follows a steady raw level exactly DEBOUNCE_CYCLES + 2 later
  task automatic track_debounce();
    for (int k = 0; k < KC; k++)
    begin
      if (key[k] !== key_prev[k])
        key_age[k] = 0;
      else
        key_age[k]++;
      if (debounced_buttons[k] !== btn_prev[k])
      begin
        if (debounced_buttons[k] !== key[k])
        begin
          other_errors++;
          $display("%s: debounced key %0d moved away from its raw level",
                   name_str(test_name), k);
        end
        else if (key_age[k] != DEBOUNCE_CYCLES + 2)
          value_error($sformatf("key %0d settle cycles", k), DEBOUNCE_CYCLES + 2, key_age[k]);
      end
      else if (key_age[k] == DEBOUNCE_CYCLES + 3 && debounced_buttons[k] !== key[k])
      begin
        other_errors++;
        $display("%s: debounced key %0d did not follow a steady raw level",
                 name_str(test_name), k);
      end
      key_prev[k] = key[k];
      btn_prev[k] = debounced_buttons[k];
    end
  endtask

  task automatic track_heartbeat();
    hb_cycles++;
    if (led[0] !== hb_level)
    begin
      if (hb_toggled)                                  // first toggle not timed
      begin
        hb_timed++;
        if (hb_cycles != HEARTBEAT_HALF)
          value_error("heartbeat spacing", HEARTBEAT_HALF, hb_cycles);
      end
      hb_toggled = 1'b1;
      hb_cycles  = 0;
      hb_level   = led[0];
    end
  endtask

  task automatic track_pulses();
    for (int k = 0; k < RRC; k++)
    begin
      if (f2h_reset_req_n[k] === 1'b0)
        low_cycles[k]++;
      else if (low_cycles[k] != 0)
      begin
        last_len[k]   = low_cycles[k];   // pulse just ended
        pulse_seen[k] = pulse_seen[k] + 1;
        low_cycles[k] = 0;
      end
    end
  endtask

  task automatic check_pulse(input int k, input int len);
    if (pulse_seen[k] != 1)
    begin
      other_errors++;
      $display("%s: %s reset request gave %0d pulses where one was expected",
               name_str(test_name), kind_name(k), pulse_seen[k]);
    end
    else if (last_len[k] != len)
      value_error({kind_name(k), " pulse length"}, len, last_len[k]);
    pulse_seen[k] = 0;
  endtask

  // falling edge, inputs and outputs settled
  always @(negedge fpga_clk_50)
  begin
    if (hps_fpga_reset_n)
    begin
      if (!reset_checked)
        check_after_reset();
      check_pass_through();
      track_debounce();
      track_heartbeat();
      track_pulses();
      if (chk_buttons && debounced_buttons !== chk_arg1[de0_glue_pkg::KEY_COUNT-1:0])
        value_error("buttons", chk_arg1, 32'(debounced_buttons));
      if (chk_pulse)
        check_pulse(int'(chk_arg1), int'(chk_arg2));
    end
  end

  always @(posedge report)
  begin
    if (hb_timed == 0)
    begin
      other_errors++;
      $display("heartbeat led never toggled twice, its spacing went unchecked");
    end
    $display("checker done: %0d value errors, %0d other errors", value_errors, other_errors);
  end

endmodule

`default_nettype wire

// ==== tb_de0_glue.sv ====
/*
 * testbench top: reads de0_glue_stim.txt from the project root, drives the glue top
 * 1 ns after the rising edge and ends the run at a cycle limit taken from the waits
 */
`default_nettype none

module tb_de0_glue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEBOUNCE_CYCLES = 16;
  localparam int HEARTBEAT_HALF  = 40;
  localparam int TIMEOUT_MARGIN  = 200;   // reset, check cycles, slack

  logic                                     fpga_clk_50;
  logic                                     hps_fpga_reset_n;
  logic [de0_glue_pkg::KEY_COUNT-1:0]       key;
  logic [de0_glue_pkg::SW_WIDTH-1:0]        sw;
  logic [de0_glue_pkg::LED_PIO_WIDTH-1:0]   led_pio;
  logic [de0_glue_pkg::RESET_REQ_COUNT-1:0] hps_reset_req;
  logic [de0_glue_pkg::LED_WIDTH-1:0]       led;
  logic [de0_glue_pkg::KEY_COUNT-1:0]       debounced_buttons;
  logic [de0_glue_pkg::RESET_REQ_COUNT-1:0] f2h_reset_req_n;
  logic [de0_glue_pkg::STM_EVENT_WIDTH-1:0] stm_hw_events;

  logic [8*16-1:0] test_name;
  logic            chk_buttons;
  logic            chk_pulse;
  int              chk_arg1;
  int              chk_arg2;
  logic            report;
  int              error_count;

  // stim table, loaded before reset ends
  string names[$];
  string cmds[$];
  int    arg1s[$];
  int    arg2s[$];
  string load_error  = "";
  int    cycle_count = 0;
  int    cycle_limit = 0;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) clock_gen_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n)
  );

  de0_glue_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .HEARTBEAT_HALF  (HEARTBEAT_HALF),
    .COLD_PULSE      (6),
    .WARM_PULSE      (2),
    .DEBUG_PULSE     (32)
  ) dut_i (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .hps_reset_req     (hps_reset_req),
    .led               (led),
    .debounced_buttons (debounced_buttons),
    .f2h_reset_req_n   (f2h_reset_req_n),
    .stm_hw_events     (stm_hw_events)
  );

  tb_checker #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .HEARTBEAT_HALF  (HEARTBEAT_HALF)
  ) checker_i (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .led               (led),
    .debounced_buttons (debounced_buttons),
    .f2h_reset_req_n   (f2h_reset_req_n),
    .stm_hw_events     (stm_hw_events),
    .test_name         (test_name),
    .chk_buttons       (chk_buttons),
    .chk_pulse         (chk_pulse),
    .chk_arg1          (chk_arg1),
    .chk_arg2          (chk_arg2),
    .report            (report),
    .error_count       (error_count)
  );

  // ============================================================
  // stimulus file
  // ============================================================
  function automatic logic [8*16-1:0] name_vec(input string s);
    logic [8*16-1:0] v;
    v = '0;
    for (int i = 0; i < s.len() && i < 16; i++)
      v = {v[8*15-1:0], s.getc(i)};
    return v;
  endfunction

  function automatic bit known_command(input string cmd, input int a1);
    if (cmd == "req" || cmd == "pulse")
      return a1 >= 0 && a1 < de0_glue_pkg::RESET_REQ_COUNT;   // kind in range
    return cmd == "keys" || cmd == "inputs" || cmd == "wait" || cmd == "buttons";
  endfunction

  task automatic load_stim();
    int    fd;
    int    n;
    int    a1;
    int    a2;
    string line;
    string name_s;
    string cmd_s;
    fd = $fopen("de0_glue_stim.txt", "r");
    if (fd == 0)
    begin
      load_error = "cannot open the stimulus file de0_glue_stim.txt";
      return;
    end
    while (!$feof(fd) && load_error == "")
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#")   // skip blanks and comments
      begin
        n = $sscanf(line, "%s %s %d %d", name_s, cmd_s, a1, a2);
        if (n != 4)
          load_error = {"stimulus line does not have four fields: ", line};
        else if (!known_command(cmd_s, a1))
          load_error = {"stimulus line has an unknown command or kind: ", line};
        else
        begin
          names.push_back(name_s);
          cmds.push_back(cmd_s);
          arg1s.push_back(a1);
          arg2s.push_back(a2);
          if (cmd_s == "wait")
            cycle_limit += a1;
        end
      end
    end
    $fclose(fd);
    cycle_limit += TIMEOUT_MARGIN;
  endtask

  // ============================================================
  // driving
  // ============================================================
  task automatic apply_command(input string cmd, input int a1, input int a2);
    if (cmd == "keys")
      key = a1[de0_glue_pkg::KEY_COUNT-1:0];
    else if (cmd == "inputs")
    begin
      sw      = a1[de0_glue_pkg::SW_WIDTH-1:0];
      led_pio = a2[de0_glue_pkg::LED_PIO_WIDTH-1:0];
    end
    else if (cmd == "req")
      hps_reset_req[de0_glue_pkg::reset_kind_e'(a1)] = a2[0];
    else if (cmd == "wait")
    begin
      repeat (a1) @(posedge fpga_clk_50);
      #1;
    end
    else
    begin
      chk_arg1    = a1;                       // checker samples on the falling edge
      chk_arg2    = a2;
      chk_buttons = (cmd == "buttons");
      chk_pulse   = (cmd == "pulse");
      @(posedge fpga_clk_50);
      #1;
      chk_buttons = 1'b0;
      chk_pulse   = 1'b0;
    end
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $finish;
  endtask

  initial
  begin
    key           = '1;                       // keys released
    sw            = '0;
    led_pio       = '0;
    hps_reset_req = '0;
    test_name     = name_vec("init");
    chk_buttons   = 1'b0;
    chk_pulse     = 1'b0;
    chk_arg1      = 0;
    chk_arg2      = 0;
    report        = 1'b0;
    load_stim();
    if (load_error != "")
      stop_with_failure(load_error);
    else
    begin
      @(posedge hps_fpga_reset_n);
      @(posedge fpga_clk_50);
      #1;
      for (int i = 0; i < names.size(); i++)
      begin
        test_name = name_vec(names[i]);
        apply_command(cmds[i], arg1s[i], arg2s[i]);
      end
      report = 1'b1;
      #1;
      if (error_count == 0)
      begin
        $display("Regression passed");
        $finish;
      end
      else
      begin
        $display("Regression failed");
        $finish;
      end
    end
  end

  // run limit
  always @(posedge fpga_clk_50)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      stop_with_failure($sformatf("the run went past its limit of %0d clock cycles",
                                  cycle_limit));
  end

endmodule

`default_nettype wire

// ==== de0_glue_stim.txt ====
# columns: test name, command, arg1, arg2 (decimal, 0 where unused)
# inputs sw led_pio | keys level | req kind level | wait cycles | buttons value | pulse kind cycles
after_reset  inputs   5 42
after_reset  buttons  3 0
glitch       keys     2 0
glitch       wait    10 0
glitch       keys     3 0
glitch       wait    40 0
glitch       buttons  3 0
hold         keys     2 0
hold         wait    40 0
hold         buttons  2 0
release      keys     3 0
release      wait    40 0
release      buttons  3 0
cold_pulse   req      0 1
cold_pulse   wait     4 0
cold_pulse   req      0 0
cold_pulse   wait    10 0
cold_pulse   pulse    0 6
warm_pulse   req      1 1
warm_pulse   wait     4 0
warm_pulse   req      1 0
warm_pulse   wait    10 0
warm_pulse   pulse    1 2
debug_pulse  req      2 1
debug_pulse  wait     4 0
debug_pulse  req      2 0
debug_pulse  wait    40 0
debug_pulse  pulse    2 32
debug_busy   req      2 1
debug_busy   wait     4 0
debug_busy   req      2 0
debug_busy   wait     4 0
debug_busy   req      2 1
debug_busy   wait     4 0
debug_busy   req      2 0
debug_busy   wait     4 0
debug_busy   req      2 1
debug_busy   wait     4 0
debug_busy   req      2 0
debug_busy   wait    40 0
debug_busy   pulse    2 32
pass_thru    inputs  10 85
pass_thru    wait    20 0
pass_thru    inputs  15 127
pass_thru    wait    20 0
pass_thru    inputs   0 0
pass_thru    wait    45 0

// ==== de0_glue.f ====
de0_glue_pkg.sv
key_debounce.sv
reset_req_pulse.sv
heartbeat_led.sv
de0_glue_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_de0_glue.sv

// ==== Makefile ====
# Verilator build and run of the board glue testbench

SIM      := verilator
TOP      := tb_de0_glue
FILELIST := de0_glue.f
FLAGS    := --binary --timing --timescale 1ns/100ps
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
